/* bench/dither_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dither_defines.svh"

module dither_tb import dither_pkg::*; ();

  localparam int line_width = 16;  // short lines keep frames small
  localparam int wait_limit = 400; // cycles before a wait gives up

  logic      clk_pixel = 1'b0;
  logic      rst_n;
  logic      in_valid;
  logic      in_ready;
  rgb565_t   in_pixel;
  hcount_t   in_hcount;
  vcount_t   in_vcount;
  gray_sel_t gray_sel;
  gray_t     threshold;
  logic      out_valid;
  logic      out_ready;
  logic      out_dot;
  gray_t     out_gray;
  hcount_t   out_hcount;
  vcount_t   out_vcount;

  integer    seed = 32'hb71f;        // pixels and input gaps
  integer    ready_seed = ~32'hb71f; // sink stalls on a separate stream
  int        cycle = 0;              // rising edges seen so far
  int        value_errs = 0;
  int        hold_errs = 0;
  int        proto_errs = 0;
  logic      gaps_on = 1'b0;         // random idle cycles on the input
  logic      bp_on = 1'b0;           // random out_ready
  logic      lat_on = 1'b0;          // latency checks active
  int        ref_carry = 0;          // model of the right carry
  int        ref_row [line_width];   // model of the error line
  dot_beat_t expect_q [$];           // predicted beats in acceptance order
  int        stamp_q [$];            // cycle of each accept
  dot_beat_t exp_beat;
  int        exp_stamp;
  dot_beat_t held_beat;
  logic      was_stalled = 1'b0;

  dither_top #(
    .line_width(line_width)
  ) UUT (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_pixel(in_pixel),
    .in_hcount(in_hcount),
    .in_vcount(in_vcount),
    .gray_sel(gray_sel),
    .threshold(threshold),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_dot(out_dot),
    .out_gray(out_gray),
    .out_hcount(out_hcount),
    .out_vcount(out_vcount)
  );

  always #50 clk_pixel = ~clk_pixel; // 100 ns period

  always @(posedge clk_pixel) cycle <= cycle + 1;

  // sink stalls about half the time when enabled
  always @(negedge clk_pixel) begin
    out_ready = bp_on ? $random(ready_seed) & 1 : 1'b1;
  end

  // gray level by the selected rule with zero padded channels
  function automatic int gray_ref(input rgb565_t pix, input gray_sel_t sel);
    int r8;
    int g8;
    int b8;
    int total;
    r8 = int'(pix[15:11]) * 8;
    g8 = int'(pix[10:5]) * 4;
    b8 = int'(pix[4:0]) * 8;
    total = r8 + g8 + b8;
    case (sel)
      red:     return r8;
      green:   return g8;
      blue:    return b8;
      default: return ((total >> 2) + (total >> 4) + (total >> 6)) % 256;
    endcase
  endfunction

  // one diffusion step on the model state
  function automatic logic diffuse_ref(input int gray, input int h, input int v, input int thr);
    int   sum;
    int   err;
    int   right;
    logic dot;
    sum = gray;
    if (h != 0) sum += ref_carry;  // nothing carried into column 0
    if (v != 0) sum += ref_row[h]; // nothing above row 0
    if (sum > 1023) sum = 1023;
    if (sum < -1024) sum = -1024;
    dot = (sum >= thr);
    err = dot ? sum - `GRAY_FULL : sum;
    right = err >>> 1;             // floor of half
    ref_carry = right;
    ref_row[h] = err - right;
    return dot;
  endfunction

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, field, got, want);
    value_errs++;
  endtask

  task automatic print_counts();
    $display("errors: %0d value, %0d hold, %0d protocol", value_errs, hold_errs, proto_errs);
  endtask

  task automatic abort_stalled(input string what);
    $display("The output stalled while %s, giving up.", what);
    print_counts();
    $display("Checks failed");
    $finish;
  endtask

  // drive one beat from a falling edge and hold it until accepted
  task automatic send_beat(input rgb565_t pix, input int h, input int v);
    int        waits;
    dot_beat_t beat;
    if (gaps_on && ($random(seed) & 3) == 0) begin
      in_valid = 1'b0; // one idle cycle
      @(negedge clk_pixel);
    end
    in_valid  = 1'b1;
    in_pixel  = pix;
    in_hcount = hcount_t'(h);
    in_vcount = vcount_t'(v);
    waits = 0;
    #1;
    if (lat_on) begin
      assert (in_ready) else begin
        $display("Input was refused although the sink never stalled.");
        proto_errs++;
      end
    end
    while (!in_ready) begin
      waits++;
      if (waits > wait_limit) abort_stalled("sending a pixel");
      @(negedge clk_pixel);
      #1;
    end
    // accepted at the coming edge so its result is predicted now
    beat.gray   = gray_t'(gray_ref(pix, gray_sel));
    beat.dot    = diffuse_ref(int'(beat.gray), h, v, int'(threshold));
    beat.hcount = hcount_t'(h);
    beat.vcount = vcount_t'(v);
    expect_q.push_back(beat);
    stamp_q.push_back(cycle);
    @(negedge clk_pixel);
  endtask

  // stop input and wait for every predicted beat to leave
  task automatic wait_drain();
    int waits;
    in_valid = 1'b0;
    waits = 0;
    while (expect_q.size() != 0) begin
      waits++;
      if (waits > wait_limit) abort_stalled("draining the pipeline");
      @(negedge clk_pixel);
    end
    @(negedge clk_pixel); // last transfer edge has passed
  endtask

  task automatic send_frame(input int rows);
    for (int v = 0; v < rows; v++) begin
      for (int h = 0; h < line_width; h++) begin
        send_beat(rgb565_t'($random(seed)), h, v);
      end
    end
  endtask

  // compares each output transfer against the queue
  always @(negedge clk_pixel) begin
    #10; // after the stimulus has settled
    if (rst_n) begin
      if (was_stalled) begin
        assert (out_valid && {out_dot, out_gray, out_hcount, out_vcount} === held_beat) else begin
          $display("** Error at %0t: output beat changed while out_ready was low", $time);
          hold_errs++;
        end
      end
      if (out_valid && out_ready) begin
        assert (expect_q.size() > 0) else begin
          $display("An output beat appeared with no input beat waiting for it.");
          proto_errs++;
        end
        if (expect_q.size() > 0) begin
          exp_beat = expect_q.pop_front();
          exp_stamp = stamp_q.pop_front();
          assert (out_dot === exp_beat.dot) else report_mismatch("out_dot", out_dot, exp_beat.dot);
          assert (out_gray === exp_beat.gray)
            else report_mismatch("out_gray", out_gray, exp_beat.gray);
          assert (out_hcount === exp_beat.hcount)
            else report_mismatch("out_hcount", out_hcount, exp_beat.hcount);
          assert (out_vcount === exp_beat.vcount)
            else report_mismatch("out_vcount", out_vcount, exp_beat.vcount);
          if (lat_on) begin
            assert (cycle - exp_stamp == 2) else begin
              $display("** Error at %0t: latency %0d cycles, expected 2", $time, cycle - exp_stamp);
              proto_errs++;
            end
          end
        end
      end
      was_stalled = out_valid && !out_ready;
      held_beat = {out_dot, out_gray, out_hcount, out_vcount};
    end
  end

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_pixel  = '0;
    in_hcount = '0;
    in_vcount = '0;
    gray_sel  = avg;
    threshold = 8'd128;
    out_ready = 1'b1;
    repeat (3) @(negedge clk_pixel);
    rst_n = 1'b1;

    // back to back beats straight out of reset at fixed latency
    lat_on = 1'b1;
    for (int h = 0; h < 12; h++) send_beat(rgb565_t'($random(seed)), h, 0);
    wait_drain();
    lat_on = 1'b0;

    // each gray rule on a single row
    threshold = 8'd255;
    for (int s = 0; s < 4; s++) begin
      gray_sel = gray_sel_t'(s);
      send_beat(16'h0000, 0, 0); // black
      send_beat(16'hffff, 1, 0); // white
      for (int h = 2; h < line_width; h++) send_beat(rgb565_t'($random(seed)), h, 0);
      wait_drain();
    end

    // full frames with gaps and stalls in the last two
    gray_sel  = avg;
    threshold = 8'd128;
    send_frame(6);
    wait_drain();
    gaps_on   = 1'b1;
    bp_on     = 1'b1;
    threshold = 8'd64;
    send_frame(6);
    wait_drain();
    threshold = 8'd200;
    send_frame(6);
    wait_drain();
    bp_on = 1'b0;

    print_counts();
    if (value_errs + hold_errs + proto_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* include/dither_defines.svh */
`ifndef DITHER_DEFINES_SVH
`define DITHER_DEFINES_SVH

// camera frame geometry
`define FRAME_WIDTH  320 // pixels per line
`define FRAME_HEIGHT 240 // lines per frame

// tag widths, sized for the video counters
`define HCOUNT_W 11 // column tag
`define VCOUNT_W 10 // row tag

// gray level width after conversion
`define GRAY_W 8

// signed error width
// holds one gray value plus both carried shares
`define ERR_W 11

// value subtracted from the sum when a dot is set
`define GRAY_FULL 255

`endif

/* source/diffusion_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dither_defines.svh"

// error diffusion ditherer
// half the error goes right, the rest goes down one row
module diffusion_core import dither_pkg::*; #(
  parameter int line_width = `FRAME_WIDTH
) (
  input  wire          clk_pixel,
  input  wire          rst_n,
  // gray stream in
  input  wire          g_valid,
  output logic         g_ready,
  input  wire gray_t   g_gray,
  input  wire hcount_t g_hcount,
  input  wire vcount_t g_vcount,
  input  wire gray_t   threshold, // dot when sum reaches this
  // dot stream out
  output logic         out_valid,
  input  wire          out_ready,
  output logic         out_dot,
  output gray_t        out_gray,
  output hcount_t      out_hcount,
  output vcount_t      out_vcount
);

  // full scale as an error value
  localparam err_t gray_full_e = err_t'(`GRAY_FULL);

  logic                      accept;
  err_t                      right_carry; // share from the pixel to the left
  err_t                      carry_term;
  err_t                      up_err;      // raw buffer read
  err_t                      up_term;
  logic signed [`ERR_W+1:0]  sum_wide;    // 13 bits, no overflow before clamp
  err_t                      sum_sat;
  err_t                      thr_ext;
  logic                      dot;
  err_t                      err_new;
  err_t                      right_share;
  err_t                      down_share;
  dot_beat_t                 beat_in;
  dot_beat_t                 beat_out;

  assign accept = g_valid && g_ready;

  // no carry into column 0, nothing above row 0
  assign carry_term = (g_hcount == '0) ? '0 : right_carry;
  assign up_term    = (g_vcount == '0) ? '0 : up_err;

  // gray zero extended, carries sign extended
  assign sum_wide = $signed({{(`ERR_W-`GRAY_W+2){1'b0}}, g_gray}) + carry_term + up_term;

  // clamp to -1024 .. 1023
  always_comb begin
    if (sum_wide > $signed({3'b000, {(`ERR_W-1){1'b1}}})) begin
      sum_sat = {1'b0, {(`ERR_W-1){1'b1}}};
    end else if (sum_wide < $signed({3'b111, {(`ERR_W-1){1'b0}}})) begin
      sum_sat = {1'b1, {(`ERR_W-1){1'b0}}};
    end else begin
      sum_sat = sum_wide[`ERR_W-1:0];
    end
  end

  assign thr_ext = {{(`ERR_W-`GRAY_W){1'b0}}, threshold}; // always positive
  assign dot     = (sum_sat >= thr_ext);

  // a set dot spends full scale, cannot underflow since sum >= 0 here
  assign err_new = dot ? (sum_sat - gray_full_e) : sum_sat;

  // floor of half, remainder goes down
  assign right_share = err_new >>> 1;
  assign down_share  = err_new - right_share;

  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      right_carry <= '0;
    end else if (accept) begin
      right_carry <= right_share;
    end
  end

  error_line_buffer #(
    .line_width(line_width)
  ) err_buf (
    .clk_pixel(clk_pixel),
    .rd_col(g_hcount),
    .rd_err(up_err),
    .wr_en(accept),       // only on a real transfer
    .wr_col(g_hcount),
    .wr_err(down_share)
  );

  always_comb begin
    beat_in.dot    = dot;
    beat_in.gray   = g_gray;
    beat_in.hcount = g_hcount;
    beat_in.vcount = g_vcount;
  end

  pipe_stage #(
    .payload_t(dot_beat_t)
  ) dot_stage (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .in_valid(g_valid),
    .in_ready(g_ready),
    .in_data(beat_in),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data(beat_out)
  );

  assign out_dot    = beat_out.dot;
  assign out_gray   = beat_out.gray;
  assign out_hcount = beat_out.hcount;
  assign out_vcount = beat_out.vcount;

endmodule

`default_nettype wire

/* source/dither_pkg.sv */
`default_nettype none

`include "dither_defines.svh"

package dither_pkg;

  typedef logic [15:0] rgb565_t; // r[15:11] g[10:5] b[4:0]

  typedef logic [`GRAY_W-1:0] gray_t;
  typedef logic signed [`ERR_W-1:0] err_t; // diffusion error or saturated sum
  typedef logic [`HCOUNT_W-1:0] hcount_t;
  typedef logic [`VCOUNT_W-1:0] vcount_t;

  // gray rule select
  typedef enum logic [1:0] {
    avg   = 2'd0, // weighted channel sum, about a third
    red   = 2'd1,
    green = 2'd2,
    blue  = 2'd3
  } gray_sel_t;

  // beat between converter and ditherer
  typedef struct packed {
    gray_t   gray;
    hcount_t hcount;
    vcount_t vcount;
  } gray_beat_t;

  // beat leaving the ditherer
  typedef struct packed {
    logic    dot; // 1 = white dot
    gray_t   gray;
    hcount_t hcount;
    vcount_t vcount;
  } dot_beat_t;

endpackage

`default_nettype wire

/* source/dither_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dither_defines.svh"

// camera pixel in, dithered dot out, two cycles when unstalled
module dither_top import dither_pkg::*; #(
  parameter int line_width = `FRAME_WIDTH
) (
  input  wire            clk_pixel,
  input  wire            rst_n,
  input  wire            in_valid,
  output logic           in_ready,
  input  wire rgb565_t   in_pixel,
  input  wire hcount_t   in_hcount,
  input  wire vcount_t   in_vcount,
  input  wire gray_sel_t gray_sel,  // gray rule
  input  wire gray_t     threshold, // dot threshold
  output logic           out_valid,
  input  wire            out_ready,
  output logic           out_dot,
  output gray_t          out_gray,
  output hcount_t        out_hcount,
  output vcount_t        out_vcount
);

  // converter to ditherer
  logic    g_valid;
  logic    g_ready;
  gray_t   g_gray;
  hcount_t g_hcount;
  vcount_t g_vcount;

  gray_convert gray_conv (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_pixel(in_pixel),
    .in_hcount(in_hcount),
    .in_vcount(in_vcount),
    .gray_sel(gray_sel),
    .g_valid(g_valid),
    .g_ready(g_ready),
    .g_gray(g_gray),
    .g_hcount(g_hcount),
    .g_vcount(g_vcount)
  );

  diffusion_core #(
    .line_width(line_width)
  ) diffuse (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .g_valid(g_valid),
    .g_ready(g_ready),
    .g_gray(g_gray),
    .g_hcount(g_hcount),
    .g_vcount(g_vcount),
    .threshold(threshold),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_dot(out_dot),
    .out_gray(out_gray),
    .out_hcount(out_hcount),
    .out_vcount(out_vcount)
  );

endmodule

`default_nettype wire

/* source/error_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dither_defines.svh"

// one row of downward error shares, indexed by column
// read is combinational, write lands on the clock edge
module error_line_buffer import dither_pkg::*; #(
  parameter int line_width = `FRAME_WIDTH // columns per row
) (
  input  wire          clk_pixel,
  // read port, current column
  input  wire hcount_t rd_col,
  output err_t         rd_err,
  // write port, share for the next row
  input  wire          wr_en,
  input  wire hcount_t wr_col,
  input  wire err_t    wr_err
);

  // index width, at least one bit even for a one column line
  localparam int col_w = (line_width > 1) ? $clog2(line_width) : 1;

  err_t             err_row [line_width]; // shares left by the row above
  logic [col_w-1:0] rd_idx;
  logic [col_w-1:0] wr_idx;

  // columns never exceed line_width - 1
  // so dropping the upper tag bits loses nothing
  assign rd_idx = rd_col[col_w-1:0];
  assign wr_idx = wr_col[col_w-1:0];

  // async read
  // same column written this cycle still reads the old entry,
  // which is the share from one row up
  assign rd_err = err_row[rd_idx];

  always_ff @(posedge clk_pixel) begin
    if (wr_en) begin
      err_row[wr_idx] <= wr_err; // overwrite once consumed
    end
  end

endmodule

`default_nettype wire

/* source/gray_convert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dither_defines.svh"

// rgb565 to 8 bit gray, one register stage
module gray_convert import dither_pkg::*; (
  input  wire            clk_pixel,
  input  wire            rst_n,
  // camera pixel stream
  input  wire            in_valid,
  output logic           in_ready,
  input  wire rgb565_t   in_pixel,
  input  wire hcount_t   in_hcount,
  input  wire vcount_t   in_vcount,
  input  wire gray_sel_t gray_sel, // sampled with each beat
  // gray stream to the ditherer
  output logic           g_valid,
  input  wire            g_ready,
  output gray_t          g_gray,
  output hcount_t        g_hcount,
  output vcount_t        g_vcount
);

  gray_t              red8;      // channels padded up to 8 bits
  gray_t              green8;
  gray_t              blue8;
  logic [`GRAY_W+1:0] chan_sum;  // 10 bits, max 748
  logic [`GRAY_W+1:0] avg_full;  // scaled sum before truncation
  gray_t              gray_next;
  gray_beat_t         beat_in;
  gray_beat_t         beat_out;

  // low bits zero filled
  assign red8   = {in_pixel[15:11], 3'b000};
  assign green8 = {in_pixel[10:5], 2'b00};
  assign blue8  = {in_pixel[4:0], 3'b000};

  assign chan_sum = {2'b00, red8} + {2'b00, green8} + {2'b00, blue8};

  // 1/4 + 1/16 + 1/64, close to a divide by three
  assign avg_full = (chan_sum >> 2) + (chan_sum >> 4) + (chan_sum >> 6);

  always_comb begin
    case (gray_sel)
      avg:     gray_next = avg_full[`GRAY_W-1:0]; // never above 244
      red:     gray_next = red8;
      green:   gray_next = green8;
      blue:    gray_next = blue8;
      default: gray_next = avg_full[`GRAY_W-1:0];
    endcase
  end

  always_comb begin
    beat_in.gray   = gray_next;
    beat_in.hcount = in_hcount; // tags ride along untouched
    beat_in.vcount = in_vcount;
  end

  pipe_stage #(
    .payload_t(gray_beat_t)
  ) gray_stage (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_data(beat_in),
    .out_valid(g_valid),
    .out_ready(g_ready),
    .out_data(beat_out)
  );

  assign g_gray   = beat_out.gray;
  assign g_hcount = beat_out.hcount;
  assign g_vcount = beat_out.vcount;

endmodule

`default_nettype wire

/* source/pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// single register slice on a valid/ready stream
// full throughput as long as the sink keeps ready high
module pipe_stage #(
  parameter type payload_t = logic [7:0] // whatever the stage carries
) (
  input  wire           clk_pixel,
  input  wire           rst_n,
  // upstream side
  input  wire           in_valid,
  output logic          in_ready,
  input  wire payload_t in_data,
  // downstream side
  output logic          out_valid,
  input  wire           out_ready,
  output payload_t      out_data
);

  logic take; // beat enters this cycle
  logic give; // held beat leaves this cycle

  assign give = out_valid && out_ready;

  // room when empty, or when the held beat drains this cycle
  assign in_ready = !out_valid || out_ready;

  assign take = in_valid && in_ready;

  // occupancy flag
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1; // refill, or replace the leaving beat
    end else if (give) begin
      out_valid <= 1'b0; // drained with nothing behind it
    end
  end

  // payload only moves on accept
  // so it stays put while the sink stalls
  always_ff @(posedge clk_pixel) begin
    if (take) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/dither_pkg.sv
source/pipe_stage.sv
source/gray_convert.sv
source/error_line_buffer.sv
source/diffusion_core.sv
source/dither_top.sv
bench/dither_tb.sv
